// ==== game.f ====
+incdir+verilog
verilog/game_pkg.sv
verilog/obstacle_row.sv
verilog/game_control.sv
verilog/max7219_driver.sv
verilog/game_top.sv
test/game_tb.sv

// ==== test/game_tb.sv ====
// Falling-obstacle game testbench
// Drives random button presses from an LFSR, tracks the game in a model,
// decodes the MAX7219 serial words and compares quiet frames with the model

`timescale 1ns/1ps
`include "game_consts.svh"

module game_tb;

	localparam int BTN_RIGHT      = 0;
	localparam int BTN_LEFT       = 1;
	localparam int BTN_START      = 2;
	localparam int ST_IDLE        = 0;
	localparam int ST_PLAY        = 1;
	localparam int ST_LOST        = 2;
	localparam int MOVE_RANDOM    = 0;
	localparam int MOVE_DODGE     = 1;
	localparam int MOVE_TO_CENTRE = 2;
	localparam int FRAME_CLKS     = 8 * 34;
	localparam int TEST_PERIODS   = 26;
	localparam int WATCHDOG_CLKS  = TEST_PERIODS * `SCROLL_PERIOD + 20 * FRAME_CLKS;

	logic clock_50 = 1'b0;
	logic rst_n;
	logic [2:0] buttons_n;
	logic max7219_din;
	logic max7219_ncs;
	logic max7219_clk;
	logic game_over;

	logic [15:0] lfsr = 16'd83;
	int cycle = 0;
	string cur_test;
	int test_checks = 0;
	int test_errors = 0;
	int total_checks = 0;
	int total_errors = 0;
	int tests_done = 0;

	// Game model
	int m_state;
	logic [7:0] m_player;
	logic [7:0] m_rows [8];
	int m_start = 0;
	int m_scrolls = 0;
	int due [3];
	logic [2:0] btn_seen;
	logic [2:0] pressed;
	logic changed;
	int last_event = -100;

	// Serial decoder
	logic ncs_prev;
	logic clk_prev;
	int bit_count = 0;
	logic [15:0] word;
	int word_count = 0;
	logic [15:0] init_words [4];
	int word_snap_cycle = -100;
	logic word_dirty = 1'b1;
	logic [63:0] word_exp;
	logic [63:0] frame_exp;
	logic [63:0] frame_act;
	logic frame_quiet = 1'b0;
	logic [7:0] digit_mask = '0;
	int frames_checked = 0;

	game_top uut (
		.clock_50    (clock_50),
		.rst_n       (rst_n),
		.start_n     (buttons_n[BTN_START]),
		.left_n      (buttons_n[BTN_LEFT]),
		.right_n     (buttons_n[BTN_RIGHT]),
		.max7219_din (max7219_din),
		.max7219_ncs (max7219_ncs),
		.max7219_clk (max7219_clk),
		.game_over   (game_over)
	);

	always #50 clock_50 = ~clock_50;

	// ##############################
	// Helpers
	// ##############################

	function automatic logic [15:0] step_lfsr(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// One LFSR step per bit taken
	task automatic take_bits(input int count, output int value);
		value = 0;
		repeat (count) begin
			value = (value << 1) | lfsr[0];
			lfsr = step_lfsr(lfsr);
		end
	endtask

	task automatic compare_value(input string what, input logic [63:0] expected,
			input logic [63:0] actual);
		test_checks++;
		total_checks++;
		assert (actual === expected) else begin
			$display("error %s %s: expected %h, actual %h", cur_test, what, expected, actual);
			test_errors++;
			total_errors++;
		end
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		test_checks = 0;
		test_errors = 0;
	endtask

	task automatic finish_test();
		tests_done++;
		$display("test %s done: %0d checks, %0d errors", cur_test, test_checks, test_errors);
	endtask

	// Rows 7 down to 0, player merged into row 0
	function automatic logic [63:0] model_matrix();
		logic [63:0] mat;
		for (int r = 0; r < 8; r++) begin
			mat[r*8 +: 8] = (r == 0) ? (m_rows[0] | m_player) : m_rows[r];
		end
		return mat;
	endfunction

	function automatic logic [7:0] moved(input logic [7:0] p, input int which);
		if (which == BTN_LEFT) begin
			return p[7] ? p : p << 1;
		end
		return p[0] ? p : p >> 1;
	endfunction

	// Keeps presses clear of the scroll edges
	function automatic bit near_scroll(input int c);
		int phase;
		if (m_state != ST_PLAY) begin
			return 1'b0;
		end
		phase = (c - m_start) % `SCROLL_PERIOD;
		return phase <= 4 || phase >= `SCROLL_PERIOD - 4;
	endfunction

	function automatic int pick_button(input int mode, input int want);
		int p;
		int d;
		logic [7:0] mask;
		p = 0;
		for (d = 0; d < 8; d++) begin
			if (m_player[d]) begin
				p = d;
			end
		end
		if (mode == MOVE_TO_CENTRE) begin
			return (p > 4) ? BTN_RIGHT : BTN_LEFT;
		end
		if (mode == MOVE_RANDOM) begin
			return want;
		end
		mask = m_rows[0] | m_rows[1];
		if ((m_player & m_rows[1]) != 0) begin
			// Threatened, head for the nearest gap in the next row
			mask = m_rows[0];
			want = -1;
			for (d = 7; d >= 1; d--) begin
				if (p - d >= 0) begin
					if (!m_rows[1][p-d]) want = BTN_RIGHT;
				end
				if (p + d < 8) begin
					if (!m_rows[1][p+d]) want = BTN_LEFT;
				end
			end
			if (want < 0) return -1;
		end
		if ((moved(m_player, want) & mask) != 0) return -1;
		return want;
	endfunction

	task automatic hold_button(input int which, input int hold);
		@(posedge clock_50);
		buttons_n[which] <= 1'b0;
		repeat (hold) @(posedge clock_50);
		buttons_n[which] <= 1'b1;
	endtask

	task automatic move_player(input int mode);
		int dir_bit;
		int hold;
		int gap;
		int which;
		take_bits(1, dir_bit);
		take_bits(4, hold);
		take_bits(8, gap);
		@(negedge clock_50);
		// Press lands three edges after the drive edge
		while (near_scroll(cycle + 4)) @(negedge clock_50);
		which = pick_button(mode, dir_bit ? BTN_LEFT : BTN_RIGHT);
		if (which >= 0) begin
			hold_button(which, hold + 4);
		end
		repeat (gap + 40) @(negedge clock_50);
	endtask

	task automatic press_start();
		@(negedge clock_50);
		hold_button(BTN_START, 8);
		repeat (40) @(negedge clock_50);
	endtask

	task automatic wait_frames(input int count);
		int target;
		target = frames_checked + count;
		while (frames_checked < target) @(negedge clock_50);
	endtask

	task automatic wait_state(input int s);
		while (m_state != s) @(negedge clock_50);
	endtask

	task automatic load_level();
		m_rows[0] = `LEVEL_ROW_0;
		m_rows[1] = `LEVEL_ROW_1;
		m_rows[2] = `LEVEL_ROW_2;
		m_rows[3] = `LEVEL_ROW_3;
		m_rows[4] = `LEVEL_ROW_4;
		m_rows[5] = `LEVEL_ROW_5;
		m_rows[6] = `LEVEL_ROW_6;
		m_rows[7] = `LEVEL_ROW_7;
	endtask

	// ##############################
	// Game model
	// ##############################

	always @(posedge clock_50) begin
		cycle++;
		if (!rst_n) begin
			m_state = ST_IDLE;
			m_player = `PLAYER_START;
			for (int r = 0; r < 8; r++) begin
				m_rows[r] = '0;
			end
			for (int b = 0; b < 3; b++) begin
				due[b] = -1;
			end
			btn_seen = 3'b111;
		end else begin
			changed = 1'b0;
			for (int b = 0; b < 3; b++) begin
				pressed[b] = (due[b] == cycle);
				// First low sample, effect two edges later
				if (btn_seen[b] && !buttons_n[b]) begin
					due[b] = cycle + 2;
				end
				btn_seen[b] = buttons_n[b];
			end
			if (pressed != 0) changed = 1'b1;
			if (m_state == ST_PLAY) begin
				if ((m_player & m_rows[0]) != 0) begin
					m_state = ST_LOST;
					changed = 1'b1;
				end else begin
					if (cycle > m_start && (cycle - m_start) % `SCROLL_PERIOD == 0) begin
						m_scrolls++;
						changed = 1'b1;
						if (m_scrolls % 8 == 0) begin
							load_level();
						end else begin
							for (int r = 0; r < 7; r++) begin
								m_rows[r] = m_rows[r+1];
							end
							m_rows[7] = '0;
						end
					end
					if (pressed[BTN_LEFT] && !m_player[7]) begin
						m_player = m_player << 1;
					end else if (pressed[BTN_RIGHT] && !m_player[0]) begin
						m_player = m_player >> 1;
					end
				end
			end else if (pressed[BTN_START]) begin
				m_state = ST_PLAY;
				load_level();
				m_player = `PLAYER_START;
				m_start = cycle;
				m_scrolls = 0;
			end
			if (changed) begin
				last_event = cycle;
				if (cycle - word_snap_cycle <= 8) word_dirty = 1'b1;
			end
		end
	end

	// ##############################
	// Serial decoder
	// ##############################

	always @(negedge clock_50) begin
		if (!rst_n) begin
			ncs_prev = 1'b1;
			clk_prev = 1'b0;
		end else begin
			if (!max7219_ncs && ncs_prev) begin
				bit_count = 0;
				word_snap_cycle = cycle;
				word_dirty = (cycle - last_event <= 8);
				word_exp = model_matrix();
			end
			if (max7219_clk && !clk_prev) begin
				word = {word[14:0], max7219_din};
				bit_count++;
			end
			if (max7219_ncs && !ncs_prev) begin
				test_checks++;
				total_checks++;
				assert (bit_count == 16) else begin
					$display("serial word %0d ended after %0d clock pulses instead of 16",
						word_count, bit_count);
					test_errors++;
					total_errors++;
				end
				if (word_count < 4) begin
					init_words[word_count] = word;
				end else if (word[15:8] >= 1 && word[15:8] <= 8) begin
					if (word[15:8] == 1) begin
						frame_exp = word_exp;
						frame_quiet = !word_dirty;
						frame_act = '0;
						digit_mask = '0;
					end
					// Digit d carries column 8-d, row 0 in the MSB
					for (int r = 0; r < 8; r++) begin
						frame_act[r*8 + 8 - word[15:8]] = word[7-r];
					end
					digit_mask[word[15:8]-1] = 1'b1;
					if (word[15:8] == 8 && digit_mask == 8'hFF && frame_quiet) begin
						compare_value("frame", frame_exp, frame_act);
						frames_checked++;
					end
				end
				word_count++;
			end
			ncs_prev = max7219_ncs;
			clk_prev = max7219_clk;
		end
	end

	// ##############################
	// Test sequence
	// ##############################

	initial begin
		buttons_n = 3'b111;
		rst_n = 1'b0;
		repeat (9) @(posedge clock_50);
		@(negedge clock_50);
		start_test("reset");
		compare_value("game_over", 64'd0, game_over);
		compare_value("ncs", 64'd1, max7219_ncs);
		@(posedge clock_50);
		rst_n <= 1'b1;
		while (word_count < 4) @(negedge clock_50);
		compare_value("init word 0", {`MAX_REG_DECODE, 8'h00}, init_words[0]);
		compare_value("init word 1", {`MAX_REG_INTENSITY, `MAX_INTENSITY}, init_words[1]);
		compare_value("init word 2", {`MAX_REG_SCANLIMIT, 8'h07}, init_words[2]);
		compare_value("init word 3", {`MAX_REG_SHUTDOWN, 8'h01}, init_words[3]);
		finish_test();

		start_test("idle");
		wait_frames(1);
		repeat (6) move_player(MOVE_RANDOM);
		wait_frames(1);
		compare_value("game_over", 64'd0, game_over);
		finish_test();

		start_test("start");
		press_start();
		wait_state(ST_PLAY);
		compare_value("game_over", 64'd0, game_over);
		wait_frames(2);
		finish_test();

		// Nine scrolls take the field through one reload
		start_test("play");
		while (m_state == ST_PLAY && m_scrolls < 9) move_player(MOVE_DODGE);
		compare_value("game_over", (m_state == ST_LOST), game_over);
		finish_test();

		start_test("collision");
		if (m_state != ST_PLAY) begin
			press_start();
			wait_state(ST_PLAY);
		end
		// Column 4 meets the 0x18 obstacle row
		while (m_state == ST_PLAY) begin
			if (m_player != 8'h10) begin
				move_player(MOVE_TO_CENTRE);
			end else begin
				@(negedge clock_50);
			end
		end
		compare_value("game_over", 64'd1, game_over);
		repeat (3) move_player(MOVE_RANDOM);
		wait_frames(2);
		compare_value("game_over frozen", 64'd1, game_over);
		press_start();
		wait_state(ST_PLAY);
		compare_value("game_over restart", 64'd0, game_over);
		wait_frames(2);
		finish_test();

		$display("%0d tests, %0d checks, %0d errors", tests_done, total_checks, total_errors);
		if (total_errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(WATCHDOG_CLKS * 100);
		$display("watchdog expired before test %s finished", cur_test);
		$display("Checks failed");
		$finish;
	end

endmodule

// ==== verilog/game_consts.svh ====
// Game constants
// Matrix size, scroll timing, MAX7219 register map and the level-1 obstacle pattern

`ifndef GAME_CONSTS_SVH
`define GAME_CONSTS_SVH

// Matrix geometry
`define MATRIX_SIZE        8

// Clocks between two obstacle scrolls
`define SCROLL_PERIOD      2048

// MAX7219 control registers
`define MAX_REG_DECODE     8'h09
`define MAX_REG_INTENSITY  8'h0A
`define MAX_REG_SCANLIMIT  8'h0B
`define MAX_REG_SHUTDOWN   8'h0C
`define MAX_INTENSITY      8'h0A

// Level 1 obstacles, bit 7 is the leftmost column
`define LEVEL_ROW_7        8'hED
`define LEVEL_ROW_6        8'h0C
`define LEVEL_ROW_5        8'h00
`define LEVEL_ROW_4        8'hC0
`define LEVEL_ROW_3        8'h00
`define LEVEL_ROW_2        8'h18
`define LEVEL_ROW_1        8'h00
`define LEVEL_ROW_0        8'h00

// Player dot on the bottom row
`define PLAYER_START       8'h10

`endif

// ==== verilog/game_control.sv ====
// Game controller
// Synchronizes the buttons, runs the idle/play/lost FSM, times the obstacle
// scrolls and reloads, moves the player and checks for a collision

`timescale 1ns/1ps
`include "game_consts.svh"

module game_control import game_pkg::*; (
	input  logic      clock_50,
	input  logic      rst_n,
	input  logic      start_n,
	input  logic      left_n,
	input  logic      right_n,
	input  row_t      bottom_row,
	output row_ctrl_t row_ctrl,
	output row_t      player,
	output logic      game_over
);

	localparam int TIMER_W = $clog2(`SCROLL_PERIOD);
	localparam logic [TIMER_W-1:0] TIMER_LAST = TIMER_W'(`SCROLL_PERIOD - 1);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_PLAY,
		ST_LOST
	} state_t;

	typedef struct packed {
		logic start;
		logic left;
		logic right;
	} buttons_t;

	state_t state;
	buttons_t btn_sync1;
	buttons_t btn_sync2;
	buttons_t btn_prev;
	buttons_t btn_press;
	logic [TIMER_W-1:0] timer;
	logic [2:0] scroll_cnt;
	logic playing;
	logic start_hit;
	logic collide;
	logic tick;
	logic reload;

	// ##############################
	// Buttons
	// ##############################

	// Two-flop synchronizer plus one flop for the falling-edge detect
	always_ff @(posedge clock_50) begin
		if (!rst_n) begin
			btn_sync1 <= '1;
			btn_sync2 <= '1;
			btn_prev  <= '1;
		end else begin
			btn_sync1 <= buttons_t'({start_n, left_n, right_n});
			btn_sync2 <= btn_sync1;
			btn_prev  <= btn_sync2;
		end
	end

	// Press is the high-to-low step of the synchronized level
	assign btn_press = buttons_t'(btn_prev & ~btn_sync2);

	// ##############################
	// Game decisions
	// ##############################

	assign playing   = (state == ST_PLAY);
	assign start_hit = btn_press.start && !playing;

	// Overlap freezes everything until the FSM reaches lost
	assign collide = playing && |(player & bottom_row);
	assign tick    = playing && !collide && (timer == TIMER_LAST);
	// every eighth scroll brings a fresh copy of the level
	assign reload  = tick && (scroll_cnt == 3'd7);

	always_comb begin
		row_ctrl = '0;
		if (state == ST_IDLE && !start_hit) begin
			row_ctrl.clear = 1'b1;
		end else if (start_hit || reload) begin
			row_ctrl.load = 1'b1;
		end else if (tick) begin
			row_ctrl.scroll = 1'b1;
		end
	end

	assign game_over = (state == ST_LOST);

	// ##############################
	// FSM and counters
	// ##############################

	always_ff @(posedge clock_50) begin
		if (!rst_n) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: begin
					if (start_hit) begin
						state <= ST_PLAY;
					end
				end
				ST_PLAY: begin
					if (collide) begin
						state <= ST_LOST;
					end
				end
				ST_LOST: begin
					if (start_hit) begin
						state <= ST_PLAY;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock_50) begin
		if (!rst_n) begin
			timer      <= '0;
			scroll_cnt <= '0;
		end else if (start_hit) begin
			timer      <= '0;
			scroll_cnt <= '0;
		end else if (playing && !collide) begin
			timer <= tick ? '0 : timer + 1'b1;
			if (tick) begin
				scroll_cnt <= scroll_cnt + 3'd1;
			end
		end
	end

	// Player register saturates at both edges
	always_ff @(posedge clock_50) begin
		if (!rst_n) begin
			player <= `PLAYER_START;
		end else if (start_hit) begin
			player <= `PLAYER_START;
		end else if (playing && !collide) begin
			if (btn_press.left && !player[`MATRIX_SIZE-1]) begin
				player <= player << 1;
			end else if (btn_press.right && !player[0]) begin
				player <= player >> 1;
			end
		end
	end

endmodule

// ==== verilog/game_pkg.sv ====
// Game types
// Shared row, row-control and MAX7219 word types

`include "game_consts.svh"

package game_pkg;

	// One matrix row, bit 7 is the leftmost column
	typedef logic [`MATRIX_SIZE-1:0] row_t;

	// Row command from the controller
	// at most one field set per cycle, clear wins over load, load over scroll
	typedef struct packed {
		logic clear;
		logic load;
		logic scroll;
	} row_ctrl_t;

	// One serial MAX7219 word, address byte goes out first
	typedef struct packed {
		logic [7:0] addr;
		logic [7:0] data;
	} max_word_t;

endpackage

// ==== verilog/game_top.sv ====
// Falling-obstacle game top level
// Controller, eight obstacle rows and the MAX7219 serial driver

`timescale 1ns/1ps
`include "game_consts.svh"

module game_top import game_pkg::*; (
	input  logic clock_50,
	input  logic rst_n,
	input  logic start_n,
	input  logic left_n,
	input  logic right_n,
	output logic max7219_din,
	output logic max7219_ncs,
	output logic max7219_clk,
	output logic game_over
);

	row_ctrl_t row_ctrl;
	row_t player;
	// One extra entry feeds zeros into the top row
	row_t rows [`MATRIX_SIZE:0];

	assign rows[`MATRIX_SIZE] = '0;

	game_control u_control (
		.clock_50   (clock_50),
		.rst_n      (rst_n),
		.start_n    (start_n),
		.left_n     (left_n),
		.right_n    (right_n),
		.bottom_row (rows[0]),
		.row_ctrl   (row_ctrl),
		.player     (player),
		.game_over  (game_over)
	);

	// ##############################
	// Obstacle field
	// ##############################

	for (genvar row = 0; row < `MATRIX_SIZE; row++) begin : g_row
		obstacle_row #(.ROW_INDEX(row)) u_row (
			.clock_50 (clock_50),
			.rst_n    (rst_n),
			.row_ctrl (row_ctrl),
			.above    (rows[row+1]),
			.row      (rows[row])
		);
	end

	max7219_driver u_driver (
		.clock_50    (clock_50),
		.rst_n       (rst_n),
		.rows        (rows[`MATRIX_SIZE-1:0]),
		.player      (player),
		.max7219_din (max7219_din),
		.max7219_ncs (max7219_ncs),
		.max7219_clk (max7219_clk)
	);

endmodule

// ==== verilog/max7219_driver.sv ====
// MAX7219 driver
// Sends the init words once, then frames of eight digit words forever.
// Each frame is a snapshot of rows and player, transposed to columns.

`timescale 1ns/1ps
`include "game_consts.svh"

module max7219_driver import game_pkg::*; (
	input  logic clock_50,
	input  logic rst_n,
	input  row_t rows [`MATRIX_SIZE-1:0],
	input  row_t player,
	output logic max7219_din,
	output logic max7219_ncs,
	output logic max7219_clk
);

	localparam int INIT_WORDS = 4;
	localparam int LAST_WORD  = INIT_WORDS + `MATRIX_SIZE - 1;
	// 16 bits, two clocks each, then ncs high for two clocks
	localparam int SHIFT_CLKS = 32;
	localparam int WORD_CLKS  = SHIFT_CLKS + 2;

	logic [5:0] cyc;
	logic [5:0] cyc_next;
	logic word_start;
	logic [3:0] widx;
	logic [2:0] col;
	row_t live [`MATRIX_SIZE-1:0];
	row_t snap [`MATRIX_SIZE-1:0];
	row_t frame [`MATRIX_SIZE-1:0];
	max_word_t next_word;
	max_word_t shift;

	// ##############################
	// Frame source
	// ##############################

	// Digit 1 reads the live matrix, the other digits read the snapshot
	always_comb begin
		for (int r = 0; r < `MATRIX_SIZE; r++) begin
			live[r]  = (r == 0) ? (rows[r] | player) : rows[r];
			frame[r] = (widx == INIT_WORDS) ? live[r] : snap[r];
		end
	end

	always_ff @(posedge clock_50) begin
		if (word_start && widx == INIT_WORDS) begin
			snap <= live;
		end
	end

	// ##############################
	// Word sequencer
	// ##############################

	// Digit d shows column 8-d
	assign col = 3'(LAST_WORD - widx);

	always_comb begin
		next_word = '0;
		case (widx)
			4'd0: next_word = '{addr: `MAX_REG_DECODE, data: 8'h00};
			4'd1: next_word = '{addr: `MAX_REG_INTENSITY, data: `MAX_INTENSITY};
			4'd2: next_word = '{addr: `MAX_REG_SCANLIMIT, data: 8'h07};
			4'd3: next_word = '{addr: `MAX_REG_SHUTDOWN, data: 8'h01};
			default: begin
				next_word.addr = 8'(widx - INIT_WORDS + 1);
				// Row 0 lands in the MSB
				for (int r = 0; r < `MATRIX_SIZE; r++) begin
					next_word.data[`MATRIX_SIZE-1-r] = frame[r][col];
				end
			end
		endcase
	end

	// ##############################
	// Serial shifter
	// ##############################

	assign word_start = (cyc == WORD_CLKS - 1);
	assign cyc_next   = word_start ? '0 : cyc + 6'd1;

	always_ff @(posedge clock_50) begin
		if (!rst_n) begin
			cyc         <= 6'(SHIFT_CLKS);
			widx        <= '0;
			shift       <= '0;
			max7219_ncs <= 1'b1;
			max7219_clk <= 1'b0;
		end else begin
			cyc         <= cyc_next;
			max7219_ncs <= (cyc_next >= SHIFT_CLKS);
			max7219_clk <= (cyc_next < SHIFT_CLKS) && cyc_next[0];
			if (word_start) begin
				shift <= next_word;
				// Init words once, then digits 1 to 8 over and over
				widx  <= (widx == LAST_WORD) ? 4'(INIT_WORDS) : widx + 4'd1;
			end else if (cyc[0]) begin
				// Next bit goes out as clk falls
				shift <= max_word_t'({shift[14:0], 1'b0});
			end
		end
	end

	// MSB first
	assign max7219_din = shift.addr[7];

endmodule

// ==== verilog/obstacle_row.sv ====
// Obstacle row
// One matrix row that clears, loads its level-1 byte or takes the row above

`timescale 1ns/1ps
`include "game_consts.svh"

module obstacle_row import game_pkg::*; #(
	parameter int ROW_INDEX = 0
) (
	input  logic      clock_50,
	input  logic      rst_n,
	input  row_ctrl_t row_ctrl,
	input  row_t      above,
	output row_t      row
);

	// Pattern byte for a given row position
	function automatic row_t level_byte(input int index);
		case (index)
			0: level_byte = `LEVEL_ROW_0;
			1: level_byte = `LEVEL_ROW_1;
			2: level_byte = `LEVEL_ROW_2;
			3: level_byte = `LEVEL_ROW_3;
			4: level_byte = `LEVEL_ROW_4;
			5: level_byte = `LEVEL_ROW_5;
			6: level_byte = `LEVEL_ROW_6;
			7: level_byte = `LEVEL_ROW_7;
			default: level_byte = '0;
		endcase
	endfunction

	localparam row_t LEVEL_BYTE = level_byte(ROW_INDEX);

	always_ff @(posedge clock_50) begin
		if (!rst_n) begin
			row <= '0;
		end else if (row_ctrl.clear) begin
			row <= '0;
		end else if (row_ctrl.load) begin
			row <= LEVEL_BYTE;
		end else if (row_ctrl.scroll) begin
			// Obstacles fall one row
			row <= above;
		end
	end

endmodule
